/* rtl/rv_mem_pkg.sv */
package rv_mem_pkg;

	// datapath widths
	localparam int XLEN           = 64;
	localparam int REG_ADDR_W     = 5;
	localparam int NUM_REGS       = 32;
	localparam int BYTE_LANES     = XLEN / 8;
	localparam int OFF_W          = $clog2(BYTE_LANES);

	// data RAM geometry, in 64-bit words
	localparam int RAM_DEPTH_LOG2 = 8;
	localparam int RAM_DEPTH      = 1 << RAM_DEPTH_LOG2;

	typedef logic [XLEN-1:0]           xlen_t;
	typedef logic [REG_ADDR_W-1:0]     reg_addr_t;
	typedef logic [RAM_DEPTH_LOG2-1:0] ram_addr_t;
	typedef logic [BYTE_LANES-1:0]     byte_mask_t;
	typedef logic [OFF_W-1:0]          byte_off_t;

	typedef enum logic [1:0] {
		SIZE_B = 2'd0, // byte
		SIZE_H = 2'd1, // half
		SIZE_W = 2'd2, // word
		SIZE_D = 2'd3  // double
	} mem_size_e;

	typedef enum logic [1:0] {
		KIND_ALU   = 2'd0,
		KIND_LOAD  = 2'd1,
		KIND_STORE = 2'd2
	} res_kind_e;

	// instruction fields from EX onward
	typedef struct packed {
		res_kind_e kind;
		mem_size_e size;
		logic      is_signed; // load extension
		logic      reg_wen;
		reg_addr_t rd;
		byte_off_t byte_off;  // low address bits
		xlen_t     alu_res;   // result, or address for load/store
		xlen_t     pc;
		logic      ebreak;
	} ex_mem_t;

	typedef struct packed {
		ex_mem_t op;
		xlen_t   load_raw; // whole RAM word, not yet aligned
	} mem_wb_t;

	// one record per retired instruction
	typedef struct packed {
		xlen_t     pc;
		reg_addr_t rd;
		xlen_t     wdata;
		logic      wen;
		logic      ebreak;
	} retire_t;

endpackage

/* rtl/mem_access_stage.sv */
`timescale 1ns/1ps

module mem_access_stage import rv_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       ex_valid_i,
	input  ex_mem_t    ex_op_i,
	input  xlen_t      ex_store_data_i,
	output ram_addr_t  ram_addr_o,
	output byte_mask_t ram_wmask_o,
	output xlen_t      ram_wdata_o,
	output logic       ex_mem_valid_o,
	output ex_mem_t    ex_mem_o
);

	byte_off_t  off;
	byte_off_t  misalign_bits; // offset bits that must be zero for this size
	byte_mask_t size_mask;
	logic       is_store;
	ex_mem_t    entry_d;

	assign off = ex_op_i.alu_res[OFF_W-1:0];
	assign ram_addr_o = ex_op_i.alu_res[OFF_W +: RAM_DEPTH_LOG2]; // word index

	always_comb begin
		unique case (ex_op_i.size)
			SIZE_B: begin
				size_mask     = 8'h01;
				misalign_bits = 3'b000;
			end
			SIZE_H: begin
				size_mask     = 8'h03;
				misalign_bits = 3'b001;
			end
			SIZE_W: begin
				size_mask     = 8'h0f;
				misalign_bits = 3'b011;
			end
			SIZE_D: begin
				size_mask     = 8'hff;
				misalign_bits = 3'b111;
			end
		endcase
	end

	assign is_store    = ex_valid_i && (ex_op_i.kind == KIND_STORE);
	assign ram_wmask_o = is_store ? byte_mask_t'(size_mask << off) : '0;

	// replicate store data so every lane the mask can pick holds it
	always_comb begin
		unique case (ex_op_i.size)
			SIZE_B: ram_wdata_o = {8{ex_store_data_i[7:0]}};
			SIZE_H: ram_wdata_o = {4{ex_store_data_i[15:0]}};
			SIZE_W: ram_wdata_o = {2{ex_store_data_i[31:0]}};
			SIZE_D: ram_wdata_o = ex_store_data_i;
		endcase
	end

	always_comb begin
		entry_d          = ex_op_i;
		entry_d.byte_off = off; // offset taken from the address
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem_valid_o <= 1'b0;
		end else begin
			ex_mem_valid_o <= ex_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (ex_valid_i) begin
			ex_mem_o <= entry_d;
		end
	end

	// loads and stores come from EX naturally aligned
	a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(ex_valid_i && ex_op_i.kind != KIND_ALU) |-> ((off & misalign_bits) == '0));

endmodule

/* rtl/data_ram.sv */
`timescale 1ns/1ps

module data_ram import rv_mem_pkg::*; (
	input  logic       clk,
	input  ram_addr_t  addr_i,
	input  byte_mask_t wmask_i,
	input  xlen_t      wdata_i,
	output xlen_t      rdata_o
);

	xlen_t mem [RAM_DEPTH];

	// read port sees the word as it was before this edge's write
	always_ff @(posedge clk) begin
		rdata_o <= mem[addr_i];
	end

	// one enable per byte lane
	always_ff @(posedge clk) begin
		for (int i = 0; i < BYTE_LANES; i++) begin
			if (wmask_i[i]) begin
				mem[addr_i][i*8 +: 8] <= wdata_i[i*8 +: 8];
			end
		end
	end

endmodule

/* rtl/mem_wb_regs.sv */
`timescale 1ns/1ps

module mem_wb_regs import rv_mem_pkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    flush_i,
	input  logic    ex_mem_valid_i,
	input  ex_mem_t ex_mem_i,
	input  xlen_t   load_raw_i,
	output logic    mem_wb_valid_o,
	output mem_wb_t mem_wb_o
);

	// flush turns the captured entry into a bubble
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb_valid_o <= 1'b0;
		end else begin
			mem_wb_valid_o <= ex_mem_valid_i & ~flush_i;
		end
	end

	// fields follow EX/MEM every cycle, flushed or not
	always_ff @(posedge clk) begin
		mem_wb_o.op       <= ex_mem_i;
		mem_wb_o.load_raw <= load_raw_i; // RAM word read at the previous edge
	end

	// a known valid keeps retire and regfile writes clean
	a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(mem_wb_valid_o));

endmodule

/* rtl/load_align_ext.sv */
`timescale 1ns/1ps

module load_align_ext import rv_mem_pkg::*; (
	input  logic      mem_wb_valid_i,
	input  mem_wb_t   mem_wb_i,
	output logic      wb_wen_o,
	output reg_addr_t wb_rd_o,
	output xlen_t     wb_data_o
);

	xlen_t shifted;
	xlen_t ext;
	logic  sgn;

	// bring the addressed byte down to lane 0
	assign shifted = mem_wb_i.load_raw >> {mem_wb_i.op.byte_off, 3'b000};
	assign sgn     = mem_wb_i.op.is_signed;

	always_comb begin
		unique case (mem_wb_i.op.size)
			SIZE_B: ext = {{(XLEN-8){sgn & shifted[7]}}, shifted[7:0]};
			SIZE_H: ext = {{(XLEN-16){sgn & shifted[15]}}, shifted[15:0]};
			SIZE_W: ext = {{(XLEN-32){sgn & shifted[31]}}, shifted[31:0]};
			SIZE_D: ext = shifted; // nothing to extend
		endcase
	end

	// stores carry their address through, retire shows it with wen low
	assign wb_data_o = (mem_wb_i.op.kind == KIND_LOAD) ? ext : mem_wb_i.op.alu_res;
	assign wb_rd_o   = mem_wb_i.op.rd;
	assign wb_wen_o  = mem_wb_valid_i && mem_wb_i.op.reg_wen
		&& (mem_wb_i.op.kind != KIND_STORE);

endmodule

/* rtl/wb_regfile.sv */
`timescale 1ns/1ps

module wb_regfile import rv_mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      wb_valid_i,
	input  logic      wb_wen_i,
	input  reg_addr_t wb_rd_i,
	input  xlen_t     wb_data_i,
	input  xlen_t     wb_pc_i,
	input  logic      wb_ebreak_i,
	input  reg_addr_t rs_addr_i,
	output xlen_t     rs_data_o,
	output logic      retire_valid_o,
	output retire_t   retire_o
);

	xlen_t regs [NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid_i && wb_wen_i && wb_rd_i != '0) begin
			regs[wb_rd_i] <= wb_data_i; // x0 never written
		end
	end

	assign rs_data_o = regs[rs_addr_i]; // decode read port

	// retire record straight from the writeback fields
	assign retire_valid_o  = wb_valid_i;
	assign retire_o.pc     = wb_pc_i;
	assign retire_o.rd     = wb_rd_i;
	assign retire_o.wdata  = wb_data_i;
	assign retire_o.wen    = wb_wen_i;
	assign retire_o.ebreak = wb_ebreak_i;

	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(rs_addr_i == '0) |-> (rs_data_o == '0));

endmodule

/* rtl/mem_wb_top.sv */
`timescale 1ns/1ps

module mem_wb_top import rv_mem_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      ex_valid_i,
	input  ex_mem_t   ex_op_i,
	input  xlen_t     ex_store_data_i,
	input  logic      flush_i,
	input  reg_addr_t rs_addr_i,
	output xlen_t     rs_data_o,
	output logic      retire_valid_o,
	output retire_t   retire_o
);

	ram_addr_t  ram_addr;
	byte_mask_t ram_wmask;
	xlen_t      ram_wdata;
	xlen_t      ram_rdata;
	logic       ex_mem_valid;
	ex_mem_t    ex_mem;
	logic       mem_wb_valid;
	mem_wb_t    mem_wb;
	logic       wb_wen;
	reg_addr_t  wb_rd;
	xlen_t      wb_data;

	mem_access_stage u_mem_access (
		.clk             (clk),
		.rst_n           (rst_n),
		.ex_valid_i      (ex_valid_i),
		.ex_op_i         (ex_op_i),
		.ex_store_data_i (ex_store_data_i),
		.ram_addr_o      (ram_addr),
		.ram_wmask_o     (ram_wmask),
		.ram_wdata_o     (ram_wdata),
		.ex_mem_valid_o  (ex_mem_valid),
		.ex_mem_o        (ex_mem)
	);

	data_ram u_data_ram (
		.clk     (clk),
		.addr_i  (ram_addr),
		.wmask_i (ram_wmask),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	mem_wb_regs u_mem_wb_regs (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush_i        (flush_i),
		.ex_mem_valid_i (ex_mem_valid),
		.ex_mem_i       (ex_mem),
		.load_raw_i     (ram_rdata),
		.mem_wb_valid_o (mem_wb_valid),
		.mem_wb_o       (mem_wb)
	);

	load_align_ext u_load_align (
		.mem_wb_valid_i (mem_wb_valid),
		.mem_wb_i       (mem_wb),
		.wb_wen_o       (wb_wen),
		.wb_rd_o        (wb_rd),
		.wb_data_o      (wb_data)
	);

	wb_regfile u_regfile (
		.clk            (clk),
		.rst_n          (rst_n),
		.wb_valid_i     (mem_wb_valid),
		.wb_wen_i       (wb_wen),
		.wb_rd_i        (wb_rd),
		.wb_data_i      (wb_data),
		.wb_pc_i        (mem_wb.op.pc),
		.wb_ebreak_i    (mem_wb.op.ebreak),
		.rs_addr_i      (rs_addr_i),
		.rs_data_o      (rs_data_o),
		.retire_valid_o (retire_valid_o),
		.retire_o       (retire_o)
	);

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o; // 10 ns period
	end

	// reset low for the first two rising edges
	initial begin
		rst_n_o = 1'b0;
		repeat (2) @(posedge clk_o);
		#1 rst_n_o = 1'b1;
	end

endmodule

/* dv/tb_mem_wb_top.sv */
`timescale 1ns/1ps

module tb_mem_wb_top import rv_mem_pkg::*; ();

	typedef struct packed {
		res_kind_e kind;
		mem_size_e size;
		logic      sgn;
		xlen_t     addr;  // address, or ALU value when rnd is 0
		reg_addr_t rd;
		logic      flush; // flush at the capture edge
		logic      rnd;   // data from the LCG
	} row_t;

	logic      clk;
	logic      rst_n;
	logic      ex_valid;
	ex_mem_t   ex_op;
	xlen_t     ex_store_data;
	logic      flush;
	reg_addr_t rs_addr;
	xlen_t     rs_data;
	logic      retire_valid;
	retire_t   retire;

	row_t      rows[$];
	string     row_names[$];
	retire_t   exp_ret[$];
	xlen_t     exp_rs[$];  // rd contents once the row has written back
	bit        table_ready;
	logic [63:0] lcg_state;
	logic [7:0]  mem_model [RAM_DEPTH*BYTE_LANES];
	xlen_t       reg_model [NUM_REGS];

	tb_clk_gen u_clk_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	mem_wb_top u_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.ex_valid_i      (ex_valid),
		.ex_op_i         (ex_op),
		.ex_store_data_i (ex_store_data),
		.flush_i         (flush),
		.rs_addr_i       (rs_addr),
		.rs_data_o       (rs_data),
		.retire_valid_o  (retire_valid),
		.retire_o        (retire)
	);

	function automatic logic [63:0] next_rand();
		lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
		return {lcg_state[31:0], lcg_state[63:32]}; // low bits of an LCG repeat quickly
	endfunction

	function automatic int size_bytes(input mem_size_e s);
		case (s)
			SIZE_B:  return 1;
			SIZE_H:  return 2;
			SIZE_W:  return 4;
			default: return 8;
		endcase
	endfunction

	function automatic xlen_t model_load(input xlen_t a, input mem_size_e s, input logic sgn);
		xlen_t v;
		int    n;
		n = size_bytes(s);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v[i*8 +: 8] = mem_model[a + i]; // little endian
		end
		if (sgn && v[n*8-1]) begin
			for (int i = n * 8; i < XLEN; i++) begin
				v[i] = 1'b1;
			end
		end
		return v;
	endfunction

	task automatic model_store(input xlen_t a, input mem_size_e s, input xlen_t d);
		for (int i = 0; i < size_bytes(s); i++) begin
			mem_model[a + i] = d[i*8 +: 8];
		end
	endtask

	task automatic check(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic add_row(input string name, input res_kind_e kind, input mem_size_e size,
			input logic sgn, input xlen_t addr, input reg_addr_t rd, input logic fl,
			input logic rnd);
		row_t r;
		r.kind  = kind;
		r.size  = size;
		r.sgn   = sgn;
		r.addr  = addr;
		r.rd    = rd;
		r.flush = fl;
		r.rnd   = rnd;
		rows.push_back(r);
		row_names.push_back(name);
	endtask

	task automatic build_table();
		add_row("alu_x1",         KIND_ALU,   SIZE_D, 0, 64'h0,   5'd1,  0, 1);
		add_row("alu_x2_fixed",   KIND_ALU,   SIZE_D, 0, 64'hdead_beef_0bad_f00d, 5'd2, 0, 0);
		add_row("alu_x0",         KIND_ALU,   SIZE_D, 0, 64'h0,   5'd0,  0, 1);
		add_row("sd_rand",        KIND_STORE, SIZE_D, 0, 64'h100, 5'd0,  0, 1);
		add_row("sd_pattern",     KIND_STORE, SIZE_D, 0, 64'h108, 5'd0,  0, 0);
		add_row("ld_rand",        KIND_LOAD,  SIZE_D, 0, 64'h100, 5'd3,  0, 0);
		add_row("lb_neg",         KIND_LOAD,  SIZE_B, 1, 64'h109, 5'd4,  0, 0);
		add_row("lbu_neg",        KIND_LOAD,  SIZE_B, 0, 64'h109, 5'd4,  0, 0);
		add_row("lb_pos",         KIND_LOAD,  SIZE_B, 1, 64'h10f, 5'd7,  0, 0);
		add_row("lh_neg",         KIND_LOAD,  SIZE_H, 1, 64'h108, 5'd8,  0, 0);
		add_row("lhu_neg",        KIND_LOAD,  SIZE_H, 0, 64'h10c, 5'd9,  0, 0);
		add_row("lw_neg",         KIND_LOAD,  SIZE_W, 1, 64'h108, 5'd10, 0, 0);
		add_row("lwu_neg",        KIND_LOAD,  SIZE_W, 0, 64'h108, 5'd11, 0, 0);
		add_row("lw_pos",         KIND_LOAD,  SIZE_W, 1, 64'h10c, 5'd12, 0, 0);
		add_row("ld_x0",          KIND_LOAD,  SIZE_D, 0, 64'h108, 5'd0,  0, 0);
		// every aligned offset for byte, half and word
		for (int i = 0; i < 8; i++) begin
			add_row($sformatf("sb_off%0d", i), KIND_STORE, SIZE_B, 0, 64'h110 + i, 0, 0, 1);
		end
		for (int i = 0; i < 8; i++) begin
			add_row($sformatf("lb_off%0d", i), KIND_LOAD, SIZE_B, i[0], 64'h110 + i,
				5'(13 + i), 0, 0);
		end
		for (int i = 0; i < 4; i++) begin
			add_row($sformatf("sh_off%0d", 2 * i), KIND_STORE, SIZE_H, 0, 64'h118 + 2 * i,
				0, 0, 1);
			add_row($sformatf("lh_off%0d", 2 * i), KIND_LOAD, SIZE_H, i[0], 64'h118 + 2 * i,
				5'(21 + i), 0, 0);
		end
		for (int i = 0; i < 2; i++) begin
			add_row($sformatf("sw_off%0d", 4 * i), KIND_STORE, SIZE_W, 0, 64'h120 + 4 * i,
				0, 0, 1);
			add_row($sformatf("lw_off%0d", 4 * i), KIND_LOAD, SIZE_W, i[0], 64'h120 + 4 * i,
				5'(25 + i), 0, 0);
		end
		add_row("alu_x5",         KIND_ALU,   SIZE_D, 0, 64'h0,   5'd5,  0, 1);
		add_row("alu_x5_flushed", KIND_ALU,   SIZE_D, 0, 64'h0,   5'd5,  1, 1);
		add_row("sd_flushed",     KIND_STORE, SIZE_D, 0, 64'h128, 5'd0,  1, 1);
		add_row("ld_flushed",     KIND_LOAD,  SIZE_D, 0, 64'h128, 5'd6,  1, 0);
		add_row("ld_after_flush", KIND_LOAD,  SIZE_D, 0, 64'h128, 5'd6,  0, 0);
		add_row("lw_same_word",   KIND_LOAD,  SIZE_W, 1, 64'h12c, 5'd27, 0, 0);
		add_row("sw_b2b",         KIND_STORE, SIZE_W, 0, 64'h130, 5'd0,  0, 1);
		add_row("lw_b2b",         KIND_LOAD,  SIZE_W, 1, 64'h130, 5'd28, 0, 0);
		add_row("alu_last",       KIND_ALU,   SIZE_D, 0, 64'h0,   5'd31, 0, 1);
	endtask

	// drive one row and work out what it should retire and write
	task automatic drive_row(input int k);
		row_t    r;
		ex_mem_t op;
		xlen_t   data;
		retire_t ret;
		r = rows[k];
		if (r.rnd) begin
			data = next_rand();
		end else begin
			data = (r.kind == KIND_STORE) ? 64'h7f01_80ff_8123_8000 : r.addr;
		end
		op           = '0;
		op.kind      = r.kind;
		op.size      = r.size;
		op.is_signed = r.sgn;
		// random stores come with reg_wen set, the fixed ALU row without
		op.reg_wen   = (r.kind != KIND_ALU) || r.rnd;
		op.rd        = r.rd;
		op.alu_res   = (r.kind == KIND_ALU) ? data : r.addr;
		op.byte_off  = op.alu_res[2:0];
		op.pc        = 64'h8000_0000 + 64'(4 * k);
		op.ebreak    = (k % 5 == 4);
		ex_valid      = 1'b1;
		ex_op         = op;
		ex_store_data = data;

		ret.pc     = op.pc;
		ret.rd     = op.rd;
		ret.wen    = op.reg_wen && (r.kind != KIND_STORE);
		ret.ebreak = op.ebreak;
		if (r.kind == KIND_LOAD) begin
			ret.wdata = model_load(r.addr, r.size, r.sgn);
		end else begin
			ret.wdata = op.alu_res; // stores show their address
		end
		if (r.kind == KIND_STORE) begin
			model_store(r.addr, r.size, data); // memory changes even when flushed
		end
		if (!r.flush && ret.wen && r.rd != '0) begin
			reg_model[r.rd] = ret.wdata;
		end
		exp_ret.push_back(ret);
		exp_rs.push_back(reg_model[r.rd]);
	endtask

	task automatic check_retire(input int j, input int n);
		logic  exp_v;
		string nm;
		exp_v = 1'b0;
		nm    = "idle";
		if (j >= 0 && j < n) begin
			exp_v = !rows[j].flush;
			nm    = row_names[j];
		end
		check({nm, " retire_valid"}, exp_v, retire_valid);
		if (exp_v) begin
			check({nm, " pc"}, exp_ret[j].pc, retire.pc);
			check({nm, " rd"}, exp_ret[j].rd, retire.rd);
			check({nm, " wdata"}, exp_ret[j].wdata, retire.wdata);
			check({nm, " wen"}, exp_ret[j].wen, retire.wen);
			check({nm, " ebreak"}, exp_ret[j].ebreak, retire.ebreak);
		end
	endtask

	initial begin
		int n;
		ex_valid      = 1'b0;
		ex_op         = '0;
		ex_store_data = '0;
		flush         = 1'b0;
		rs_addr       = '0;
		lcg_state     = 64'd95243;
		for (int i = 0; i < NUM_REGS; i++) begin
			reg_model[i] = '0;
		end
		build_table();
		n = rows.size();
		table_ready = 1'b1;

		wait (rst_n === 1'b1);
		@(posedge clk);
		// retire of row k shows two loop passes later, its register one more
		for (int k = 0; k < n + 3; k++) begin
			#1;
			if (k < n) begin
				drive_row(k);
			end else begin
				ex_valid      = 1'b0;
				ex_op         = '0;
				ex_store_data = '0;
			end
			flush   = 1'b0;
			rs_addr = '0;
			if (k >= 1 && k <= n) begin
				flush = rows[k-1].flush; // seen at the MEM/WB capture edge
			end
			if (k >= 3 && k - 3 < n) begin
				rs_addr = rows[k-3].rd;
			end
			@(negedge clk);
			check_retire(k - 2, n);
			if (k >= 3 && k - 3 < n) begin
				check({row_names[k-3], " rs_data"}, exp_rs[k-3], rs_data);
			end
			@(posedge clk);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

	initial begin
		wait (table_ready);
		#((rows.size() + 10) * 10);
		$display("timeout: the run did not finish within %0d cycles", rows.size() + 10);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

/* sources.f */
rtl/rv_mem_pkg.sv
rtl/mem_access_stage.sv
rtl/data_ram.sv
rtl/mem_wb_regs.sv
rtl/load_align_ext.sv
rtl/wb_regfile.sv
rtl/mem_wb_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_wb_top.sv

/* Bender.yml */
package:
  name: rv_mem_wb

sources:
  - rtl/rv_mem_pkg.sv
  - rtl/mem_access_stage.sv
  - rtl/data_ram.sv
  - rtl/mem_wb_regs.sv
  - rtl/load_align_ext.sv
  - rtl/wb_regfile.sv
  - rtl/mem_wb_top.sv
  - target: simulation
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_mem_wb_top.sv
